// ==== logic/rv_fetch_pkg.sv ====
`default_nettype none

package rv_fetch_pkg;

localparam int XLEN = 32;
localparam int PARCEL_W = 16;

// One tagged instruction, as handed to decode
typedef struct packed {
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] instr;
	logic            is_32bit;
	logic            invalid;
} fetch_entry_t;

// Compressed operations recognized
typedef enum logic [4:0] {
	C_ADDI4SPN,
	C_LW,
	C_SW,
	C_ADDI,
	C_JAL,
	C_J,
	C_LI,
	C_LUI_ADDI16SP,
	C_SRLI,
	C_SRAI,
	C_ANDI,
	C_SUB,
	C_XOR,
	C_OR,
	C_AND,
	C_SLLI,
	C_LWSP,
	C_SWSP,
	C_JR_MV,
	C_JALR_ADD,
	C_BEQZ,
	C_BNEZ,
	C_ILLEGAL
} rvc_op_e;

// RVC quadrants, instr[1:0]
localparam logic [1:0] RVC_Q0 = 2'b00;
localparam logic [1:0] RVC_Q1 = 2'b01;
localparam logic [1:0] RVC_Q2 = 2'b10;

localparam logic [4:0] REG_ZERO = 5'd0;
localparam logic [4:0] REG_RA   = 5'd1;
localparam logic [4:0] REG_SP   = 5'd2;

// Major opcodes
localparam logic [6:0] OPC_OP     = 7'b0110011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_JALR   = 7'b1100111;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;

localparam logic [2:0] F3_ADD_SUB = 3'b000;
localparam logic [2:0] F3_SLL     = 3'b001;
localparam logic [2:0] F3_XOR     = 3'b100;
localparam logic [2:0] F3_SRL_SRA = 3'b101;
localparam logic [2:0] F3_OR      = 3'b110;
localparam logic [2:0] F3_AND     = 3'b111;
localparam logic [2:0] F3_LW      = 3'b010;
localparam logic [2:0] F3_SW      = 3'b010;
localparam logic [2:0] F3_BEQ     = 3'b000;
localparam logic [2:0] F3_BNE     = 3'b001;
localparam logic [2:0] F3_JALR    = 3'b000;

localparam logic [6:0] F7_BASE = 7'b0000000;
localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRAI

// Field positions
localparam int RD_LSB     = 7;
localparam int FUNCT3_LSB = 12;
localparam int RS1_LSB    = 15;
localparam int RS2_LSB    = 20;
localparam int FUNCT7_LSB = 25;

endpackage

`default_nettype wire

// ==== logic/instr_stream_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface instr_stream_if import rv_fetch_pkg::*; ();

logic            valid;
logic            ready;
logic [XLEN-1:0] pc;
logic [XLEN-1:0] instr;
logic            is_32bit;
logic            invalid;

modport source (
	output valid, pc, instr, is_32bit, invalid,
	input  ready
);

modport sink (
	input  valid, pc, instr, is_32bit, invalid,
	output ready
);

endinterface

`default_nettype wire

// ==== logic/fetch_word_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_word_buffer import rv_fetch_pkg::*; #(
	parameter int FETCH_DEPTH = 2
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            mem_valid,
	input  logic [XLEN-1:0] mem_data,
	output logic            mem_credit,
	output logic            word_valid,
	output logic [XLEN-1:0] word_data,
	input  logic            word_ready
);

localparam int PTR_W = (FETCH_DEPTH > 1) ? $clog2(FETCH_DEPTH) : 1;
localparam int CNT_W = $clog2(FETCH_DEPTH + 1);

logic [XLEN-1:0]  words [FETCH_DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic             pop;

function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
	if (p == PTR_W'(FETCH_DEPTH - 1))
		return '0;
	return p + 1'b1;
endfunction

assign word_valid = count != '0;
assign word_data = words[rd_ptr];
assign pop = word_valid && word_ready;

always_ff @(posedge clk) begin
	if (mem_valid)
		words[wr_ptr] <= mem_data;
end

always_ff @(posedge clk) begin
	if (reset) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
		mem_credit <= 1'b0;
	end else begin
		mem_credit <= pop; // One credit back per word consumed
		if (mem_valid)
			wr_ptr <= ptr_inc(wr_ptr);
		if (pop)
			rd_ptr <= ptr_inc(rd_ptr);
		case ({mem_valid, pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: ;
		endcase
	end
end

// Sender must hold a credit, so a full buffer never sees a new word
a_no_overrun: assert property (@(posedge clk) disable iff (reset)
	mem_valid |-> count < CNT_W'(FETCH_DEPTH));

endmodule

`default_nettype wire

// ==== logic/instr_aligner.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_aligner import rv_fetch_pkg::*; #(
	parameter bit              HAS_C    = 1'b1,
	parameter logic [XLEN-1:0] RESET_PC = '0
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            word_valid,
	input  logic [XLEN-1:0] word_data,
	output logic            word_ready,
	instr_stream_if.source  align_if
);

logic                residue_valid;
logic [PARCEL_W-1:0] residue;
logic [XLEN-1:0]     pc;
logic [PARCEL_W-1:0] parcel;
logic                nxt_is_32bit;
logic [XLEN-1:0]     nxt_instr;
logic                need_word;
logic                out_free;
logic                fire;

// Oldest unconsumed parcel
assign parcel = residue_valid ? residue : word_data[PARCEL_W-1:0];

// Length decision for the whole front end
assign nxt_is_32bit = !HAS_C || (parcel[1:0] == 2'b11);

// A lone 16-bit residue can leave without a new word
assign need_word = !residue_valid || nxt_is_32bit;

assign out_free = !align_if.valid || align_if.ready;
assign fire = out_free && (word_valid || !need_word);
assign word_ready = out_free && need_word;

assign align_if.invalid = 1'b0;

always_comb begin
	if (!nxt_is_32bit)
		nxt_instr = {{(XLEN - PARCEL_W){1'b0}}, parcel};
	else if (residue_valid)
		nxt_instr = {word_data[PARCEL_W-1:0], residue}; // Straddles two words
	else
		nxt_instr = word_data;
end

always_ff @(posedge clk) begin
	if (word_valid && word_ready)
		residue <= word_data[XLEN-1:PARCEL_W];
end

always_ff @(posedge clk) begin
	if (fire) begin
		align_if.pc <= pc;
		align_if.instr <= nxt_instr;
		align_if.is_32bit <= nxt_is_32bit;
	end
end

always_ff @(posedge clk) begin
	if (reset) begin
		residue_valid <= 1'b0;
		pc <= RESET_PC;
		align_if.valid <= 1'b0;
	end else begin
		if (out_free)
			align_if.valid <= fire;
		if (fire) begin
			pc <= pc + (nxt_is_32bit ? XLEN'(4) : XLEN'(2));
			// Upper half stays behind unless a full word went out
			residue_valid <= need_word && (residue_valid || !nxt_is_32bit);
		end
	end
end

a_pc_even: assert property (@(posedge clk) disable iff (reset)
	align_if.valid |-> !align_if.pc[0]);

endmodule

`default_nettype wire

// ==== logic/instr_decompress.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decompress import rv_fetch_pkg::*; #(
	parameter bit HAS_C = 1'b1
) (
	instr_stream_if.sink   align_if,
	instr_stream_if.source expand_if
);

logic [PARCEL_W-1:0] c;
rvc_op_e             op;
logic [4:0]          rd_l;
logic [4:0]          rs2_l;
logic [4:0]          rs1_s;
logic [4:0]          rs2_s;
logic [11:0]         imm_ci;
logic [11:0]         imm_mem;
logic [12:0]         imm_cb;
logic [20:0]         imm_cj;
logic [XLEN-1:0]     rvc_instr;
logic                rvc_invalid;
logic                expand;

function automatic logic [XLEN-1:0] enc_r(
	input logic [6:0] f7,
	input logic [4:0] rs2,
	input logic [4:0] rs1,
	input logic [2:0] f3,
	input logic [4:0] rd,
	input logic [6:0] opc
);
	logic [XLEN-1:0] r;
	r = '0;
	r[6:0] = opc;
	r[RD_LSB +: 5] = rd;
	r[FUNCT3_LSB +: 3] = f3;
	r[RS1_LSB +: 5] = rs1;
	r[RS2_LSB +: 5] = rs2;
	r[FUNCT7_LSB +: 7] = f7;
	return r;
endfunction

// I-type shares the R layout, imm over funct7 and rs2
function automatic logic [XLEN-1:0] enc_i(
	input logic [11:0] imm,
	input logic [4:0]  rs1,
	input logic [2:0]  f3,
	input logic [4:0]  rd,
	input logic [6:0]  opc
);
	return enc_r(imm[11:5], imm[4:0], rs1, f3, rd, opc);
endfunction

assign c = align_if.instr[PARCEL_W-1:0];

assign rd_l  = c[11:7]; // Also rs1 of CR/CI
assign rs2_l = c[6:2];
assign rs1_s = {2'b01, c[9:7]};
assign rs2_s = {2'b01, c[4:2]}; // Also rd' of CIW/CL

assign imm_ci  = {{7{c[12]}}, c[6:2]};
assign imm_mem = {5'b0, c[5], c[12:10], c[6], 2'b00};
assign imm_cb  = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
assign imm_cj  = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};

always_comb begin
	op = C_ILLEGAL;
	if (c != '0) begin
		case (c[1:0])
			RVC_Q0: begin
				case (c[15:13])
					3'b000: op = C_ADDI4SPN;
					3'b010: op = C_LW;
					3'b110: op = C_SW;
					default: ;
				endcase
			end
			RVC_Q1: begin
				case (c[15:13])
					3'b000: op = C_ADDI;
					3'b001: op = C_JAL;
					3'b010: op = C_LI;
					3'b011: op = C_LUI_ADDI16SP;
					3'b100: begin
						case (c[11:10])
							2'b00: op = c[12] ? C_ILLEGAL : C_SRLI;
							2'b01: op = c[12] ? C_ILLEGAL : C_SRAI;
							2'b10: op = C_ANDI;
							default: begin
								if (!c[12]) begin
									case (c[6:5])
										2'b00: op = C_SUB;
										2'b01: op = C_XOR;
										2'b10: op = C_OR;
										default: op = C_AND;
									endcase
								end
							end
						endcase
					end
					3'b101: op = C_J;
					3'b110: op = C_BEQZ;
					default: op = C_BNEZ;
				endcase
			end
			RVC_Q2: begin
				case (c[15:13])
					3'b000: op = c[12] ? C_ILLEGAL : C_SLLI; // shamt[5] reserved on RV32
					3'b010: op = C_LWSP;
					3'b100: op = c[12] ? C_JALR_ADD : C_JR_MV;
					3'b110: op = C_SWSP;
					default: ;
				endcase
			end
			default: ;
		endcase
	end
end

always_comb begin
	rvc_instr = '0;
	rvc_invalid = 1'b0;
	case (op)
		C_ADDI4SPN: rvc_instr = enc_i({2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00},
			REG_SP, F3_ADD_SUB, rs2_s, OPC_OP_IMM);
		C_LW: rvc_instr = enc_i(imm_mem, rs1_s, F3_LW, rs2_s, OPC_LOAD);
		C_SW: rvc_instr = enc_r(imm_mem[11:5], rs2_s, rs1_s, F3_SW, imm_mem[4:0], OPC_STORE);
		C_ADDI: rvc_instr = enc_i(imm_ci, rd_l, F3_ADD_SUB, rd_l, OPC_OP_IMM);
		C_JAL: rvc_instr = {imm_cj[20], imm_cj[10:1], imm_cj[11], imm_cj[19:12], REG_RA, OPC_JAL};
		C_J: rvc_instr = {imm_cj[20], imm_cj[10:1], imm_cj[11], imm_cj[19:12], REG_ZERO, OPC_JAL};
		C_LI: rvc_instr = enc_i(imm_ci, REG_ZERO, F3_ADD_SUB, rd_l, OPC_OP_IMM);
		C_LUI_ADDI16SP: begin
			if (rd_l == REG_SP)
				rvc_instr = enc_i({{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0},
					REG_SP, F3_ADD_SUB, REG_SP, OPC_OP_IMM);
			else
				rvc_instr = {{14{c[12]}}, c[12], c[6:2], rd_l, OPC_LUI};
			rvc_invalid = {c[12], c[6:2]} == 6'h0; // Zero immediate reserved
		end
		C_SRLI: rvc_instr = enc_r(F7_BASE, c[6:2], rs1_s, F3_SRL_SRA, rs1_s, OPC_OP_IMM);
		C_SRAI: rvc_instr = enc_r(F7_ALT, c[6:2], rs1_s, F3_SRL_SRA, rs1_s, OPC_OP_IMM);
		C_ANDI: rvc_instr = enc_i(imm_ci, rs1_s, F3_AND, rs1_s, OPC_OP_IMM);
		C_SUB: rvc_instr = enc_r(F7_ALT, rs2_s, rs1_s, F3_ADD_SUB, rs1_s, OPC_OP);
		C_XOR: rvc_instr = enc_r(F7_BASE, rs2_s, rs1_s, F3_XOR, rs1_s, OPC_OP);
		C_OR: rvc_instr = enc_r(F7_BASE, rs2_s, rs1_s, F3_OR, rs1_s, OPC_OP);
		C_AND: rvc_instr = enc_r(F7_BASE, rs2_s, rs1_s, F3_AND, rs1_s, OPC_OP);
		C_SLLI: rvc_instr = enc_r(F7_BASE, c[6:2], rd_l, F3_SLL, rd_l, OPC_OP_IMM);
		C_LWSP: rvc_instr = enc_i({4'b0, c[3:2], c[12], c[6:4], 2'b00},
			REG_SP, F3_LW, rd_l, OPC_LOAD);
		C_SWSP: rvc_instr = enc_r({4'b0, c[8:7], c[12]}, rs2_l, REG_SP, F3_SW,
			{c[11:9], 2'b00}, OPC_STORE);
		C_JR_MV: begin
			if (rs2_l == REG_ZERO) begin
				rvc_instr = enc_i(12'h0, rd_l, F3_JALR, REG_ZERO, OPC_JALR);
				rvc_invalid = rd_l == REG_ZERO; // JR x0 reserved
			end else begin
				rvc_instr = enc_r(F7_BASE, rs2_l, REG_ZERO, F3_ADD_SUB, rd_l, OPC_OP);
			end
		end
		C_JALR_ADD: begin
			if (rs2_l == REG_ZERO) begin
				rvc_instr = enc_i(12'h0, rd_l, F3_JALR, REG_RA, OPC_JALR);
				rvc_invalid = rd_l == REG_ZERO; // C.EBREAK not supported
			end else begin
				rvc_instr = enc_r(F7_BASE, rs2_l, rd_l, F3_ADD_SUB, rd_l, OPC_OP);
			end
		end
		C_BEQZ: rvc_instr = enc_r({imm_cb[12], imm_cb[10:5]}, REG_ZERO, rs1_s, F3_BEQ,
			{imm_cb[4:1], imm_cb[11]}, OPC_BRANCH);
		C_BNEZ: rvc_instr = enc_r({imm_cb[12], imm_cb[10:5]}, REG_ZERO, rs1_s, F3_BNE,
			{imm_cb[4:1], imm_cb[11]}, OPC_BRANCH);
		default: rvc_invalid = 1'b1;
	endcase
end

assign expand = HAS_C && !align_if.is_32bit;

assign expand_if.valid = align_if.valid;
assign align_if.ready = expand_if.ready;
assign expand_if.pc = align_if.pc;
assign expand_if.is_32bit = align_if.is_32bit;
assign expand_if.instr = expand ? rvc_instr : align_if.instr;
assign expand_if.invalid = align_if.invalid || (expand && rvc_invalid);

endmodule

`default_nettype wire

// ==== logic/decode_credit_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_credit_queue import rv_fetch_pkg::*; #(
	parameter int QUEUE_DEPTH = 4,
	parameter int DEC_CREDITS = 4
) (
	input  logic         clk,
	input  logic         reset,
	instr_stream_if.sink expand_if,
	input  logic         dec_credit,
	output logic         out_valid,
	output fetch_entry_t out_entry
);

localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);
localparam int CRD_W = $clog2(DEC_CREDITS + 1);

fetch_entry_t     entries [QUEUE_DEPTH];
logic [PTR_W-1:0] wr_ptr;
logic [PTR_W-1:0] rd_ptr;
logic [CNT_W-1:0] count;
logic [CRD_W-1:0] credits;
logic             push;

function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
	if (p == PTR_W'(QUEUE_DEPTH - 1))
		return '0;
	return p + 1'b1;
endfunction

assign expand_if.ready = count != CNT_W'(QUEUE_DEPTH);
assign push = expand_if.valid && expand_if.ready;

// Send only with space reserved downstream
assign out_valid = (count != '0) && (credits != '0);
assign out_entry = entries[rd_ptr];

always_ff @(posedge clk) begin
	if (push)
		entries[wr_ptr] <= '{pc: expand_if.pc, instr: expand_if.instr,
			is_32bit: expand_if.is_32bit, invalid: expand_if.invalid};
end

always_ff @(posedge clk) begin
	if (reset) begin
		wr_ptr <= '0;
		rd_ptr <= '0;
		count <= '0;
		credits <= CRD_W'(DEC_CREDITS);
	end else begin
		if (push)
			wr_ptr <= ptr_inc(wr_ptr);
		if (out_valid)
			rd_ptr <= ptr_inc(rd_ptr);
		case ({push, out_valid})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: ;
		endcase
		case ({out_valid, dec_credit})
			2'b10: credits <= credits - 1'b1;
			2'b01: credits <= credits + 1'b1;
			default: ;
		endcase
	end
end

// Decode never returns more than it was given
a_credit_bound: assert property (@(posedge clk) disable iff (reset)
	credits <= CRD_W'(DEC_CREDITS));

endmodule

`default_nettype wire

// ==== logic/fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend import rv_fetch_pkg::*; #(
	parameter int              FETCH_DEPTH = 2,
	parameter int              QUEUE_DEPTH = 4,
	parameter int              DEC_CREDITS = 4,
	parameter bit              HAS_C       = 1'b1,
	parameter logic [XLEN-1:0] RESET_PC    = 32'h0000_0000
) (
	input  logic            clk,
	input  logic            reset,
	input  logic            mem_valid,
	input  logic [XLEN-1:0] mem_data,
	output logic            mem_credit,
	output logic            out_valid,
	output logic [XLEN-1:0] out_pc,
	output logic [XLEN-1:0] out_instr,
	output logic            out_is_32bit,
	output logic            out_invalid,
	input  logic            dec_credit
);

logic            word_valid;
logic            word_ready;
logic [XLEN-1:0] word_data;
fetch_entry_t    out_entry;

instr_stream_if align_if ();
instr_stream_if expand_if ();

fetch_word_buffer #(
	.FETCH_DEPTH (FETCH_DEPTH)
) u_buffer (
	.clk        (clk),
	.reset      (reset),
	.mem_valid  (mem_valid),
	.mem_data   (mem_data),
	.mem_credit (mem_credit),
	.word_valid (word_valid),
	.word_data  (word_data),
	.word_ready (word_ready)
);

instr_aligner #(
	.HAS_C    (HAS_C),
	.RESET_PC (RESET_PC)
) u_aligner (
	.clk        (clk),
	.reset      (reset),
	.word_valid (word_valid),
	.word_data  (word_data),
	.word_ready (word_ready),
	.align_if   (align_if.source)
);

instr_decompress #(
	.HAS_C (HAS_C)
) u_decompress (
	.align_if  (align_if.sink),
	.expand_if (expand_if.source)
);

decode_credit_queue #(
	.QUEUE_DEPTH (QUEUE_DEPTH),
	.DEC_CREDITS (DEC_CREDITS)
) u_queue (
	.clk        (clk),
	.reset      (reset),
	.expand_if  (expand_if.sink),
	.dec_credit (dec_credit),
	.out_valid  (out_valid),
	.out_entry  (out_entry)
);

assign out_pc = out_entry.pc;
assign out_instr = out_entry.instr;
assign out_is_32bit = out_entry.is_32bit;
assign out_invalid = out_entry.invalid;

endmodule

`default_nettype wire

// ==== tb/rvc_ref_model.svh ====
`ifndef RVC_REF_MODEL_SVH
`define RVC_REF_MODEL_SVH

// Returns {invalid, expanded instruction}; illegal parcels expand to zero
function automatic logic [32:0] rvc_expand(input logic [15:0] c);
	logic [4:0]  rd;
	logic [4:0]  rs2;
	logic [4:0]  rdp;
	logic [4:0]  rs1p;
	logic [11:0] imm;
	logic [20:0] j;
	logic [12:0] b;
	logic [31:0] i;
	logic        bad;
	logic [2:0]  f3;
	rd = c[11:7];
	rs2 = c[6:2];
	rdp = {2'b01, c[4:2]};
	rs1p = {2'b01, c[9:7]};
	j = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
	b = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};
	imm = {5'b0, c[5], c[12:10], c[6], 2'b00}; // CL/CS word offset
	i = 32'h0;
	bad = 1'b0;
	case ({c[15:13], c[1:0]})
		5'b000_00: begin
			i = {2'b0, c[10:7], c[12:11], c[5], c[6], 2'b00, 5'd2, 3'b000, rdp, 7'h13};
			bad = c == 16'h0;
			if (bad)
				i = 32'h0;
		end
		5'b010_00: i = {imm, rs1p, 3'b010, rdp, 7'h03};
		5'b110_00: i = {imm[11:5], rdp, rs1p, 3'b010, imm[4:0], 7'h23};
		5'b000_01: i = {{7{c[12]}}, c[6:2], rd, 3'b000, rd, 7'h13};
		5'b001_01: i = {j[20], j[10:1], j[11], j[19:12], 5'd1, 7'h6f};
		5'b101_01: i = {j[20], j[10:1], j[11], j[19:12], 5'd0, 7'h6f};
		5'b010_01: i = {{7{c[12]}}, c[6:2], 5'd0, 3'b000, rd, 7'h13};
		5'b011_01: begin
			if (rd == 5'd2)
				i = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0, 5'd2, 3'b000, 5'd2, 7'h13};
			else
				i = {{15{c[12]}}, c[6:2], rd, 7'h37};
			bad = {c[12], c[6:2]} == 6'h0;
		end
		5'b100_01: begin
			if (c[11:10] == 2'b10)
				i = {{7{c[12]}}, c[6:2], rs1p, 3'b111, rs1p, 7'h13};
			else if (c[12])
				bad = 1'b1; // RV32 shamt[5] and reserved ALU ops
			else if (c[11:10] == 2'b00)
				i = {7'h00, c[6:2], rs1p, 3'b101, rs1p, 7'h13};
			else if (c[11:10] == 2'b01)
				i = {7'h20, c[6:2], rs1p, 3'b101, rs1p, 7'h13};
			else begin
				f3 = (c[6:5] == 2'b00) ? 3'b000 : (c[6:5] == 2'b01) ? 3'b100 :
					(c[6:5] == 2'b10) ? 3'b110 : 3'b111;
				i = {(c[6:5] == 2'b00) ? 7'h20 : 7'h00, rdp, rs1p, f3, rs1p, 7'h33};
			end
		end
		5'b110_01: i = {b[12], b[10:5], 5'd0, rs1p, 3'b000, b[4:1], b[11], 7'h63};
		5'b111_01: i = {b[12], b[10:5], 5'd0, rs1p, 3'b001, b[4:1], b[11], 7'h63};
		5'b000_10: begin
			if (c[12])
				bad = 1'b1;
			else
				i = {7'h00, c[6:2], rd, 3'b001, rd, 7'h13};
		end
		5'b010_10: i = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, rd, 7'h03};
		5'b110_10: i = {4'b0, c[8:7], c[12], rs2, 5'd2, 3'b010, c[11:9], 2'b00, 7'h23};
		5'b100_10: begin
			if (rs2 == 5'd0) begin
				i = {12'h0, rd, 3'b000, c[12] ? 5'd1 : 5'd0, 7'h67};
				bad = rd == 5'd0; // JR x0 and EBREAK
			end else begin
				i = {7'h00, rs2, c[12] ? rd : 5'd0, 3'b000, rd, 7'h33};
			end
		end
		default: bad = 1'b1;
	endcase
	return {bad, i};
endfunction

// Random program image and the entries it should produce
task automatic build_image();
	int           idx;
	logic [31:0]  r;
	logic [15:0]  c;
	logic [32:0]  x;
	fetch_entry_t e;
	idx = 0;
	while (idx < 2 * NUM_WORDS) begin
		r = $random(seed);
		e.pc = 32'(idx * 2);
		if (r[2:0] < 3'd3 && idx < 2 * NUM_WORDS - 1) begin
			r = $random(seed);
			r[1:0] = 2'b11;
			hw[idx] = r[15:0];
			hw[idx + 1] = r[31:16];
			e.instr = r;
			e.is_32bit = 1'b1;
			e.invalid = 1'b0;
			idx += 2;
		end else begin
			if (r[7:3] == 5'd0)
				c = 16'h0000;
			else if (r[7:3] == 5'd1)
				c = 16'h9002; // C.EBREAK
			else begin
				c = r[31:16];
				if (c[1:0] == 2'b11)
					c[1:0] = {1'b0, r[8]};
			end
			x = rvc_expand(c);
			hw[idx] = c;
			e.instr = x[31:0];
			e.invalid = x[32];
			e.is_32bit = 1'b0;
			idx += 1;
		end
		expected.push_back(e);
	end
	words_used = (idx + 1) / 2;
endtask

`endif

// ==== tb/tb_fetch_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend import rv_fetch_pkg::*; ();

localparam int FETCH_DEPTH = 2;
localparam int QUEUE_DEPTH = 4;
localparam int DEC_CREDITS = 4;
localparam int NUM_WORDS = 256;
localparam int MAX_CYCLES = 40000;

logic            clk;
logic            reset;
logic            mem_valid;
logic [XLEN-1:0] mem_data;
logic            mem_credit;
logic            out_valid;
logic [XLEN-1:0] out_pc;
logic [XLEN-1:0] out_instr;
logic            out_is_32bit;
logic            out_invalid;
logic            dec_credit;

logic [15:0]  hw [2 * NUM_WORDS];
fetch_entry_t expected [$];
integer       seed = 93;
int           words_used;

`include "rvc_ref_model.svh"

fetch_frontend #(
	.FETCH_DEPTH (FETCH_DEPTH),
	.QUEUE_DEPTH (QUEUE_DEPTH),
	.DEC_CREDITS (DEC_CREDITS),
	.HAS_C       (1'b1),
	.RESET_PC    (32'h0000_0000)
) dut0 (
	.clk          (clk),
	.reset        (reset),
	.mem_valid    (mem_valid),
	.mem_data     (mem_data),
	.mem_credit   (mem_credit),
	.out_valid    (out_valid),
	.out_pc       (out_pc),
	.out_instr    (out_instr),
	.out_is_32bit (out_is_32bit),
	.out_invalid  (out_invalid),
	.dec_credit   (dec_credit)
);

task automatic stop_with_failure(input string what);
	$display("ERROR at %0t: %s", $time, what);
	$display("Verification failed");
	$fatal(1);
endtask

task automatic compare_instr(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		stop_with_failure("wrong instruction word");
	end
endtask

task automatic compare_pc(input string name, input logic [XLEN-1:0] got,
		input logic [XLEN-1:0] exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
		stop_with_failure("wrong PC");
	end
endtask

task automatic compare_flag(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
		stop_with_failure("wrong flag");
	end
endtask

initial begin
	clk = 1'b0;
	forever #2 clk = ~clk;
end

initial begin
	int           cycles;
	int           words_sent;
	int           mem_creds;
	int           credit_pulses;
	int           outputs;
	int           returned;
	int           owed;
	int           stall;
	int           tail;
	logic [31:0]  r;
	fetch_entry_t e;
	reset = 1'b1;
	mem_valid = 1'b0;
	mem_data = '0;
	dec_credit = 1'b0;
	build_image();
	repeat (2) @(posedge clk);
	#1 reset = 1'b0;
	cycles = 0;
	words_sent = 0;
	mem_creds = FETCH_DEPTH;
	credit_pulses = 0;
	outputs = 0;
	returned = 0;
	owed = 0;
	stall = 0;
	tail = 0;
	while (tail < 6) begin
		@(posedge clk);
		#1;
		cycles++;
		if (cycles > MAX_CYCLES)
			stop_with_failure("timeout waiting for the instruction stream");
		if (words_sent == 0 && (out_valid || mem_credit))
			stop_with_failure("output active before any word was sent");
		if (mem_credit) begin
			credit_pulses++;
			mem_creds++;
		end
		if (mem_creds > FETCH_DEPTH)
			stop_with_failure("mem_credit returned for a word never consumed");
		if (out_valid) begin
			if (outputs >= returned + DEC_CREDITS)
				stop_with_failure("output sent without credit");
			if (expected.size() == 0)
				stop_with_failure("output beyond the end of the program");
			e = expected.pop_front();
			compare_pc("out_pc", out_pc, e.pc);
			compare_flag("out_is_32bit", out_is_32bit, e.is_32bit);
			compare_instr("out_instr", out_instr, e.instr);
			compare_flag("out_invalid", out_invalid, e.invalid);
			outputs++;
			owed++;
		end
		// Memory only sends while it holds a credit
		r = $random(seed);
		mem_valid = 1'b0;
		if (mem_creds > 0 && words_sent < NUM_WORDS && r[1:0] != 2'b00) begin
			mem_valid = 1'b1;
			mem_data = {hw[2 * words_sent + 1], hw[2 * words_sent]};
			words_sent++;
			mem_creds--;
		end
		dec_credit = 1'b0;
		if (stall > 0)
			stall--;
		else if (r[11:6] == 6'd0)
			stall = 30 + int'(r[16:12]); // Long decode stall
		else if (owed > 0 && r[3:2] != 2'b00) begin
			dec_credit = 1'b1;
			owed--;
			returned++;
		end
		if (expected.size() == 0)
			tail++;
	end
	mem_valid = 1'b0;
	dec_credit = 1'b0;
	if (credit_pulses != words_used) begin
		$display("ERROR: %0d mem_credit pulses for %0d words consumed", credit_pulses,
			words_used);
		stop_with_failure("memory credit count wrong");
	end else begin
		$display("Verification passed");
		$finish;
	end
end

endmodule

`default_nettype wire

// ==== fetch_frontend.f ====
+incdir+tb
logic/rv_fetch_pkg.sv
logic/instr_stream_if.sv
logic/fetch_word_buffer.sv
logic/instr_aligner.sv
logic/instr_decompress.sv
logic/decode_credit_queue.sv
logic/fetch_frontend.sv
tb/tb_fetch_frontend.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f fetch_frontend.f \
	--top-module tb_fetch_frontend -o sim_fetch_frontend
./obj_dir/sim_fetch_frontend > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
	exit 1
fi
grep -q "Verification passed" sim.log
